// ==== Makefile ====
TOP := jts16_game_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000

clean:
	rm -rf obj_dir

// ==== jts16_cen.sv ====
/* Pixel clock enables
   pxl2_cen runs at the full clock rate, pxl_cen at half of it */

module jts16_cen (
    input  logic clk,
    input  logic rst,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic half;

    always_ff @(posedge clk) begin
        if (rst) begin
            half     <= 1'b0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            pxl2_cen <= 1'b1;
            // Divide the double-rate strobe by two
            if (pxl2_cen) begin
                half <= ~half;
            end
            pxl_cen <= pxl2_cen & half;
        end
    end

endmodule

// ==== jts16_cfg.svh ====
/* Tile video configuration
   Layer count, raster geometry and graphics ROM widths shared by
   the whole video subsystem */

`ifndef JTS16_CFG_SVH
`define JTS16_CFG_SVH

// Number of scroll layers behind the mixer
`define JTS16_LAYERS 3

// Horizontal raster, in pixels
`define JTS16_HTOTAL 320
`define JTS16_HVIS 256

// Vertical raster, in lines
`define JTS16_VTOTAL 262
`define JTS16_VVIS 224

// Graphics ROM word address width (32-bit words)
`define JTS16_ROMAW 16

// Horizontal scroll register width
`define JTS16_SCRW 9

`endif

// ==== jts16_game.sv ====
/* Tile video subsystem top level
   Clock enables, video timer, scroll layers, ROM arbiter and mixer */

`include "jts16_cfg.svh"

module jts16_game (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [`JTS16_LAYERS-1:0][`JTS16_SCRW-1:0] scroll_x,
    // Graphics ROM
    output logic                                     rom_valid,
    output logic [`JTS16_ROMAW-1:0]                  rom_addr,
    input  logic                                     rom_ready,
    input  logic                                     rom_dok,
    input  logic [31:0]                              rom_data,
    // Video
    output logic [4:0]                               red,
    output logic [4:0]                               green,
    output logic [4:0]                               blue,
    output logic                                     LHBL_dly,
    output logic                                     LVBL_dly,
    output logic                                     HS,
    output logic                                     VS,
    output logic                                     pxl_cen
);

    import jts16_pkg::*;

    localparam int LAYERS = `JTS16_LAYERS;

    logic [8:0]                          hdump;
    logic [8:0]                          vrender;
    logic                                LHBL;
    logic                                LVBL;
    logic [LAYERS-1:0]                   req_valid;
    logic [LAYERS-1:0][`JTS16_ROMAW-1:0] req_addr;
    logic [LAYERS-1:0]                   req_ready;
    logic [LAYERS-1:0]                   rsp_ok;
    logic [31:0]                         rsp_data;
    logic [LAYERS-1:0][3:0]              lyr_pxl;

    jts16_cen u_cen (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl2_cen (          ),
        .pxl_cen  ( pxl_cen  )
    );

    jts16_vtimer u_vtimer (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .hdump    ( hdump    ),
        .vrender  ( vrender  ),
        .LHBL     ( LHBL     ),
        .LVBL     ( LVBL     ),
        .HS       ( HS       ),
        .VS       ( VS       )
    );

    for (genvar i = 0; i < LAYERS; i++) begin : g_layer
        jts16_scroll #(.LAYER(layer_idx_t'(i))) u_scroll (
            .clk       ( clk          ),
            .rst       ( rst          ),
            .pxl_cen   ( pxl_cen      ),
            .hdump     ( hdump        ),
            .vrender   ( vrender      ),
            .scroll_x  ( scroll_x[i]  ),
            .req_valid ( req_valid[i] ),
            .req_addr  ( req_addr[i]  ),
            .req_ready ( req_ready[i] ),
            .rsp_ok    ( rsp_ok[i]    ),
            .rsp_data  ( rsp_data     ),
            .pxl       ( lyr_pxl[i]   )
        );
    end

    jts16_rom_arb u_rom_arb (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .req_valid ( req_valid ),
        .req_addr  ( req_addr  ),
        .req_ready ( req_ready ),
        .rsp_ok    ( rsp_ok    ),
        .rsp_data  ( rsp_data  ),
        .rom_valid ( rom_valid ),
        .rom_addr  ( rom_addr  ),
        .rom_ready ( rom_ready ),
        .rom_dok   ( rom_dok   ),
        .rom_data  ( rom_data  )
    );

    jts16_mix u_mix (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .pxl      ( lyr_pxl  ),
        .LHBL     ( LHBL     ),
        .LVBL     ( LVBL     ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly )
    );

endmodule

// ==== jts16_game_assert.sv ====
/* Video subsystem checker
   Tracks its own raster position and scroll latch, and checks timing,
   the ROM port and the mixed RGB stream against the ROM data rule */

`include "jts16_cfg.svh"

module jts16_game_assert (
    input logic                                     clk,
    input logic                                     rst,
    input logic                                     pxl_cen,
    input logic [8:0]                               hdump,
    input logic [8:0]                               vrender,
    input logic [`JTS16_LAYERS-1:0][`JTS16_SCRW-1:0] scroll_x,
    input logic                                     rom_valid,
    input logic [`JTS16_ROMAW-1:0]                  rom_addr,
    input logic                                     rom_ready,
    input logic                                     rom_dok,
    input logic [4:0]                               red,
    input logic [4:0]                               green,
    input logic [4:0]                               blue,
    input logic                                     LHBL_dly,
    input logic                                     LVBL_dly,
    input logic                                     HS,
    input logic                                     VS
);

    localparam int LAYERS = `JTS16_LAYERS;
    localparam int HTOT   = `JTS16_HTOTAL;
    localparam int VTOT   = `JTS16_VTOTAL;

    typedef logic [LAYERS-1:0][`JTS16_SCRW-1:0] scr_t;

    int         fail_cnt = 0;
    logic [8:0] ch;
    logic [8:0] cv;
    logic [8:0] d1_h;
    logic [8:0] d1_v;
    logic [8:0] d2_h;
    logic [8:0] d2_v;
    scr_t       lat;
    scr_t       d1_scr;
    scr_t       d2_scr;
    logic       armed;
    logic       seen_cen;
    logic       outstanding;
    logic [14:0] exp_rgb;
    logic       addr_good;

    function automatic logic [3:0] tile_pix(input int l, input logic [8:0] h,
                                            input logic [8:0] v, input logic [8:0] s);
        logic [8:0]  sx;
        logic [15:0] addr;
        logic [31:0] data;
        sx   = h + s;
        addr = 16'(l * 16384 + int'(v) * 64 + int'(sx) / 8);
        data = {16'd0, addr} * 32'h9E3779B1;
        return data[4*sx[2:0] +: 4];
    endfunction

    // Layer 0 on top and zero when every layer is transparent
    function automatic logic [14:0] mix_rgb(input logic [8:0] h, input logic [8:0] v,
                                            input scr_t scr);
        logic [3:0]  p;
        logic [14:0] rgb;
        rgb = '0;
        for (int l = LAYERS - 1; l >= 0; l--) begin
            p = tile_pix(l, h, v, scr[l]);
            if (p != 4'd0) begin
                rgb = {p, 1'b0, 5'(l * 8), 5'd31 - {1'b0, p}};
            end
        end
        return rgb;
    endfunction

    // Address must be the current or next tile of some layer
    function automatic logic addr_match(input logic [15:0] a, input logic [8:0] h,
                                        input logic [8:0] v, input scr_t scr);
        logic        pre;
        logic        hit;
        logic [8:0]  col;
        logic [8:0]  line;
        logic [5:0]  cur;
        logic [5:0]  nxt;
        logic [15:0] base;
        pre  = int'(h) >= HTOT - 16;
        line = v;
        if (pre) begin
            line = (int'(v) == VTOT - 1) ? 9'd0 : v + 9'd1;
        end
        hit = 1'b0;
        // Lines past 255 spill into the next layer's address range
        for (int l = 0; l < LAYERS; l++) begin
            col  = h + scr[l] + (pre ? 9'(512 - HTOT) : 9'd0);
            cur  = col[8:3];
            nxt  = cur + 6'd1;
            base = 16'(l * 16384 + int'(line) * 64);
            if ((a == base + 16'(cur)) || (a == base + 16'(nxt))) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_comb begin
        exp_rgb   = mix_rgb(d2_h, d2_v, d2_scr);
        addr_good = addr_match(rom_addr, ch, cv, lat);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ch          <= '0;
            cv          <= '0;
            d1_h        <= '0;
            d1_v        <= '0;
            d2_h        <= '0;
            d2_v        <= '0;
            lat         <= '0;
            d1_scr      <= '0;
            d2_scr      <= '0;
            armed       <= 1'b0;
            seen_cen    <= 1'b0;
            outstanding <= 1'b0;
        end else begin
            if (VS) begin
                armed <= 1'b1;
            end
            if (rom_valid && rom_ready) begin
                outstanding <= 1'b1;
            end else if (rom_dok) begin
                outstanding <= 1'b0;
            end
            if (pxl_cen) begin
                seen_cen <= 1'b1;
                ch       <= (int'(ch) == HTOT - 1) ? 9'd0 : ch + 9'd1;
                if (int'(ch) == HTOT - 1) begin
                    cv <= (int'(cv) == VTOT - 1) ? 9'd0 : cv + 9'd1;
                end
                // Scroll is taken for the next line
                if (int'(ch) == HTOT - 17) begin
                    lat <= scroll_x;
                end
                d1_h   <= ch;
                d1_v   <= cv;
                d1_scr <= lat;
                d2_h   <= d1_h;
                d2_v   <= d1_v;
                d2_scr <= d1_scr;
            end
        end
    end

    a_raster: assert property (@(posedge clk) disable iff (rst)
        hdump == ch && vrender == cv)
        else begin $error("[ERROR] %0t: raster counters off", $time); fail_cnt++; end

    a_cen_hi: assert property (@(posedge clk) disable iff (rst || !armed)
        pxl_cen |=> !pxl_cen)
        else begin $error("[ERROR] %0t: pxl_cen high twice", $time); fail_cnt++; end

    a_cen_lo: assert property (@(posedge clk) disable iff (rst || !armed)
        !pxl_cen |=> pxl_cen)
        else begin $error("[ERROR] %0t: pxl_cen low twice", $time); fail_cnt++; end

    a_sync: assert property (@(posedge clk) disable iff (rst)
        HS == (ch >= 9'd280 && ch <= 9'd303) && VS == (cv >= 9'd240 && cv <= 9'd242))
        else begin $error("[ERROR] %0t: sync position wrong", $time); fail_cnt++; end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        rom_valid && !rom_ready |=> rom_valid && $stable(rom_addr))
        else begin $error("[ERROR] %0t: ROM request dropped", $time); fail_cnt++; end

    a_single: assert property (@(posedge clk) disable iff (rst)
        !(rom_valid && rom_ready && outstanding) && !(rom_dok && !outstanding))
        else begin $error("[ERROR] %0t: ROM access overlap", $time); fail_cnt++; end

    a_addr: assert property (@(posedge clk) disable iff (rst || !armed)
        rom_valid |-> addr_good)
        else begin $error("[ERROR] %0t: bad ROM address %h", $time, rom_addr); fail_cnt++; end

    a_blank: assert property (@(posedge clk) disable iff (rst || !armed)
        LHBL_dly == (d2_h < 9'(`JTS16_HVIS)) && LVBL_dly == (d2_v < 9'(`JTS16_VVIS)))
        else begin $error("[ERROR] %0t: blanking misaligned", $time); fail_cnt++; end

    a_rgb: assert property (@(posedge clk) disable iff (rst || !armed)
        LHBL_dly && LVBL_dly |-> {red, green, blue} == exp_rgb)
        else begin $error("[ERROR] %0t: RGB %h, expected %h", $time,
                          {red, green, blue}, exp_rgb); fail_cnt++; end

    a_rgb_off: assert property (@(posedge clk) disable iff (rst)
        !(LHBL_dly && LVBL_dly) |-> {red, green, blue} == 15'd0)
        else begin $error("[ERROR] %0t: colour in blanking", $time); fail_cnt++; end

    a_reset: assert property (@(posedge clk) disable iff (rst)
        !seen_cen |-> !rom_valid && !HS && !VS && {red, green, blue} == 15'd0)
        else begin $error("[ERROR] %0t: outputs active after reset", $time); fail_cnt++; end

endmodule

bind jts16_game jts16_game_assert u_game_assert (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .pxl_cen   ( pxl_cen   ),
    .hdump     ( hdump     ),
    .vrender   ( vrender   ),
    .scroll_x  ( scroll_x  ),
    .rom_valid ( rom_valid ),
    .rom_addr  ( rom_addr  ),
    .rom_ready ( rom_ready ),
    .rom_dok   ( rom_dok   ),
    .red       ( red       ),
    .green     ( green     ),
    .blue      ( blue      ),
    .LHBL_dly  ( LHBL_dly  ),
    .LVBL_dly  ( LVBL_dly  ),
    .HS        ( HS        ),
    .VS        ( VS        )
);

// ==== jts16_game_tb.sv ====
/* Tile video subsystem testbench
   Clock, reset, graphics ROM model with random stalls and latency,
   and scroll stimulus over three frames */

`include "jts16_cfg.svh"

module jts16_game_tb;

    localparam int LAYERS = `JTS16_LAYERS;
    // Four frames of clocks at two clocks per pixel
    localparam int LIMIT  = 4 * `JTS16_HTOTAL * `JTS16_VTOTAL * 2;

    logic                                     clk;
    logic                                     rst;
    logic [LAYERS-1:0][`JTS16_SCRW-1:0]       scroll_x;
    logic                                     rom_valid;
    logic [`JTS16_ROMAW-1:0]                  rom_addr;
    logic                                     rom_ready;
    logic                                     rom_dok;
    logic [31:0]                              rom_data;
    logic [4:0]                               red;
    logic [4:0]                               green;
    logic [4:0]                               blue;
    logic                                     LHBL_dly;
    logic                                     LVBL_dly;
    logic                                     HS;
    logic                                     VS;
    logic                                     pxl_cen;

    integer                  seed = 32'he299_6481;
    int                      cycles = 0;
    int                      lat_cnt = 0;
    logic                    stalled = 1'b0;
    logic [`JTS16_ROMAW-1:0] acc_addr = '0;

    jts16_game u_jts16_game (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .scroll_x  ( scroll_x  ),
        .rom_valid ( rom_valid ),
        .rom_addr  ( rom_addr  ),
        .rom_ready ( rom_ready ),
        .rom_dok   ( rom_dok   ),
        .rom_data  ( rom_data  ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .LHBL_dly  ( LHBL_dly  ),
        .LVBL_dly  ( LVBL_dly  ),
        .HS        ( HS        ),
        .VS        ( VS        ),
        .pxl_cen   ( pxl_cen   )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Graphics ROM contents
    function automatic logic [31:0] rom_word(input logic [`JTS16_ROMAW-1:0] a);
        return {16'd0, a} * 32'h9E3779B1;
    endfunction

    // ROM model with ready low for one cycle at most and a short latency after a stall
    always @(negedge clk) begin
        if (rst) begin
            rom_ready = 1'b0;
            rom_dok   = 1'b0;
            stalled   = 1'b0;
            lat_cnt   = 0;
        end else begin
            rom_dok = 1'b0;
            if (lat_cnt != 0) begin
                lat_cnt = lat_cnt - 1;
                if (lat_cnt == 0) begin
                    rom_dok  = 1'b1;
                    rom_data = rom_word(acc_addr);
                end
            end
            if (!rom_ready) begin
                rom_ready = 1'b1;
            end else begin
                rom_ready = ($random(seed) & 7) != 0;
            end
            if (rom_valid && !rom_ready) begin
                stalled = 1'b1;
            end
            if (rom_valid && rom_ready) begin
                acc_addr = rom_addr;
                lat_cnt  = stalled ? 1 : 1 + int'($unsigned($random(seed)) % 32'd3);
                stalled  = 1'b0;
            end
        end
    end

    task automatic pick_scroll();
        for (int i = 0; i < LAYERS; i++) begin
            scroll_x[i] = `JTS16_SCRW'($random(seed));
        end
    endtask

    // Counts frames by the rising edge of VS
    task automatic wait_frames(input int n);
        int   seen;
        logic vs_q;
        seen = 0;
        vs_q = VS;
        while (seen < n) begin
            @(negedge clk);
            if (VS && !vs_q) begin
                seen++;
            end
            vs_q = VS;
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", LIMIT);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clk) begin
        if (u_jts16_game.u_game_assert.fail_cnt != 0) begin
            $display("Result: FAILED");
            $fatal(1, "checker assertion failed");
        end
    end

    initial begin
        rst       = 1'b1;
        rom_ready = 1'b0;
        rom_dok   = 1'b0;
        rom_data  = '0;
        scroll_x  = '0;
        pick_scroll();
        repeat (16) @(negedge clk);
        rst = 1'b0;
        wait_frames(2);
        pick_scroll();
        wait_frames(1);
        @(negedge clk);
        if (u_jts16_game.u_game_assert.fail_cnt != 0) begin
            $display("Result: FAILED");
            $fatal(1, "checker assertion failed");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== jts16_mix.sv ====
/* Layer mixer
   Fixed priority with layer 0 on top, colour index mapped to RGB
   and blanked outside the active area */

`include "jts16_cfg.svh"

module jts16_mix (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           pxl_cen,
    input  logic [`JTS16_LAYERS-1:0][3:0]  pxl,
    input  logic                           LHBL,
    input  logic                           LVBL,
    output logic [4:0]                     red,
    output logic [4:0]                     green,
    output logic [4:0]                     blue,
    output logic                           LHBL_dly,
    output logic                           LVBL_dly
);

    import jts16_pkg::*;

    layer_idx_t win;
    logic [3:0] win_idx;
    logic [4:0] r_c;
    logic [4:0] g_c;
    logic [4:0] b_c;
    logic       lhbl1;
    logic       lvbl1;

    always_comb begin
        win     = '0;
        win_idx = 4'd0;
        // Walk upwards so the lowest opaque layer is kept
        for (int k = `JTS16_LAYERS - 1; k >= 0; k--) begin
            if (pxl[k] != 4'd0) begin
                win     = layer_idx_t'(k);
                win_idx = pxl[k];
            end
        end
        r_c = {win_idx, 1'b0};
        g_c = 5'(win) << 3;
        b_c = 5'd31 - {1'b0, win_idx};
        if (win_idx == 4'd0) begin
            r_c = 5'd0;
            g_c = 5'd0;
            b_c = 5'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lhbl1    <= 1'b0;
            lvbl1    <= 1'b0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            red      <= 5'd0;
            green    <= 5'd0;
            blue     <= 5'd0;
        end else if (pxl_cen) begin
            // Layer pixels already carry one pixel of delay
            lhbl1    <= LHBL;
            lvbl1    <= LVBL;
            LHBL_dly <= lhbl1;
            LVBL_dly <= lvbl1;
            red      <= (lhbl1 && lvbl1) ? r_c : 5'd0;
            green    <= (lhbl1 && lvbl1) ? g_c : 5'd0;
            blue     <= (lhbl1 && lvbl1) ? b_c : 5'd0;
        end
    end

endmodule

// ==== jts16_pkg.sv ====
/* Tile video types
   Layer index and the arbiter and layer fetch state encodings */

`include "jts16_cfg.svh"

package jts16_pkg;

    // Layer number, wide enough for every layer
    typedef logic [$clog2(`JTS16_LAYERS)-1:0] layer_idx_t;

    // ROM arbiter
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_REQ  = 2'd1,
        ARB_WAIT = 2'd2
    } arb_state_e;

    // Tile fetch of one scroll layer
    typedef enum logic [1:0] {
        FETCH_READY   = 2'd0,
        FETCH_PENDING = 2'd1,
        FETCH_LOADED  = 2'd2
    } fetch_state_e;

endpackage

// ==== jts16_rom_arb.sv ====
/* Graphics ROM arbiter
   Round-robin over the layer requests with a single outstanding
   access on the valid/ready ROM port */

`include "jts16_cfg.svh"

module jts16_rom_arb (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [`JTS16_LAYERS-1:0]                  req_valid,
    input  logic [`JTS16_LAYERS-1:0][`JTS16_ROMAW-1:0] req_addr,
    output logic [`JTS16_LAYERS-1:0]                  req_ready,
    output logic [`JTS16_LAYERS-1:0]                  rsp_ok,
    output logic [31:0]                               rsp_data,
    output logic                                      rom_valid,
    output logic [`JTS16_ROMAW-1:0]                   rom_addr,
    input  logic                                      rom_ready,
    input  logic                                      rom_dok,
    input  logic [31:0]                               rom_data
);

    import jts16_pkg::*;

    localparam int LAYERS = `JTS16_LAYERS;

    arb_state_e state;
    layer_idx_t owner;
    layer_idx_t pick;
    logic       pick_vld;
    logic       grant;
    int         nxt;

    // Search starts just after the last served layer
    always_comb begin
        pick_vld = 1'b0;
        pick     = owner;
        nxt      = 0;
        for (int k = 1; k <= LAYERS; k++) begin
            nxt = (int'(owner) + k) % LAYERS;
            if (!pick_vld && req_valid[nxt]) begin
                pick_vld = 1'b1;
                pick     = layer_idx_t'(nxt);
            end
        end
        // A new owner can follow a data return back to back
        grant = pick_vld && ((state == ARB_IDLE) || (state == ARB_WAIT && rom_dok));
    end

    always_comb begin
        req_ready        = '0;
        rsp_ok           = '0;
        req_ready[owner] = (state == ARB_REQ) && rom_ready;
        rsp_ok[owner]    = (state == ARB_WAIT) && rom_dok;
    end

    assign rom_valid = state == ARB_REQ;
    assign rsp_data  = rom_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ARB_IDLE;
            owner <= layer_idx_t'(LAYERS - 1);
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (grant) begin
                        owner <= pick;
                        state <= ARB_REQ;
                    end
                end
                ARB_REQ: begin
                    if (rom_ready) begin
                        state <= ARB_WAIT;
                    end
                end
                ARB_WAIT: begin
                    if (grant) begin
                        owner <= pick;
                        state <= ARB_REQ;
                    end else if (rom_dok) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            rom_addr <= req_addr[pick];
        end
    end

endmodule

// ==== jts16_scroll.sv ====
/* Scroll layer
   Fetches one 32-bit tile word per eight pixels one tile ahead and
   shifts it out a nibble per pixel, lowest nibble first */

`include "jts16_cfg.svh"

module jts16_scroll #(
    parameter jts16_pkg::layer_idx_t LAYER = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  logic [8:0]              hdump,
    input  logic [8:0]              vrender,
    input  logic [`JTS16_SCRW-1:0]  scroll_x,
    output logic                    req_valid,
    output logic [`JTS16_ROMAW-1:0] req_addr,
    input  logic                    req_ready,
    input  logic                    rsp_ok,
    input  logic [31:0]             rsp_data,
    output logic [3:0]              pxl
);

    import jts16_pkg::*;

    localparam int AW = `JTS16_ROMAW;
    // Last 16 pixels of a line prefetch the start of the next line
    localparam logic [8:0] PRE  = 9'(`JTS16_HTOTAL - 16);
    localparam logic [8:0] HTOT = 9'(`JTS16_HTOTAL);
    localparam logic [8:0] HVIS = 9'(`JTS16_HVIS);
    localparam logic [8:0] VMAX = 9'(`JTS16_VTOTAL - 1);

    fetch_state_e           fst;
    logic                   stale;
    logic [`JTS16_SCRW-1:0] scr_lat;
    logic                   pre;
    logic [8:0]             col;
    logic [8:0]             line;
    logic [5:0]             tile_nxt;
    logic                   tile_start;
    logic                   fetch_en;
    logic                   have_data;
    logic                   busy;
    logic [31:0]            tile_buf;
    logic [31:0]            shifter;
    logic [31:0]            load_word;
    logic [AW-1:0]          next_addr;

    always_comb begin
        pre  = hdump >= PRE;
        // Column keeps counting across the line wrap
        col  = hdump + scr_lat - (pre ? HTOT : 9'd0);
        line = vrender;
        if (pre) begin
            line = (vrender == VMAX) ? 9'd0 : vrender + 9'd1;
        end
        tile_start = col[2:0] == 3'd0;
        tile_nxt   = col[8:3] + 6'd1;
        fetch_en   = (hdump < HVIS) || pre;
        next_addr  = (AW'(LAYER) << 14) + (AW'(line) << 6) + AW'(tile_nxt);
        have_data  = (fst == FETCH_LOADED) || (rsp_ok && !stale);
        busy       = (fst == FETCH_PENDING) && !rsp_ok;
        load_word  = '0;
        if (have_data) begin
            load_word = (fst == FETCH_LOADED) ? tile_buf : rsp_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fst       <= FETCH_READY;
            stale     <= 1'b0;
            req_valid <= 1'b0;
            scr_lat   <= '0;
            pxl       <= 4'd0;
        end else begin
            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end
            if (rsp_ok) begin
                // Late words are dropped
                fst   <= stale ? FETCH_READY : FETCH_LOADED;
                stale <= 1'b0;
            end
            if (pxl_cen) begin
                if (hdump == PRE - 9'd1) begin
                    scr_lat <= scroll_x;
                end
                if (tile_start) begin
                    pxl <= load_word[3:0];
                    if (fetch_en && busy) begin
                        stale <= 1'b1;
                    end else if (fetch_en) begin
                        fst       <= FETCH_PENDING;
                        req_valid <= 1'b1;
                        req_addr  <= next_addr;
                    end else if (!busy) begin
                        fst <= FETCH_READY;
                    end
                end else begin
                    pxl <= shifter[3:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_ok) begin
            tile_buf <= rsp_data;
        end
        if (pxl_cen) begin
            shifter <= tile_start ? {4'd0, load_word[31:4]} : {4'd0, shifter[31:4]};
        end
    end

endmodule

// ==== jts16_vtimer.sv ====
/* Video timer
   Pixel and line counters with blanking and sync decoded one step
   ahead, so every output changes on the same pxl_cen as hdump */

`include "jts16_cfg.svh"

module jts16_vtimer (
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    output logic [8:0] hdump,
    output logic [8:0] vrender,
    output logic       LHBL,
    output logic       LVBL,
    output logic       HS,
    output logic       VS
);

    localparam logic [8:0] HMAX = 9'(`JTS16_HTOTAL - 1);
    localparam logic [8:0] VMAX = 9'(`JTS16_VTOTAL - 1);
    localparam logic [8:0] HVIS = 9'(`JTS16_HVIS);
    localparam logic [8:0] VVIS = 9'(`JTS16_VVIS);

    // Sync pulses sit inside the blanking intervals
    localparam logic [8:0] HS_START = 9'(`JTS16_HVIS + 24);
    localparam logic [8:0] HS_END   = 9'(`JTS16_HVIS + 47);
    localparam logic [8:0] VS_START = 9'(`JTS16_VVIS + 16);
    localparam logic [8:0] VS_END   = 9'(`JTS16_VVIS + 18);

    logic       line_end;
    logic [8:0] hnext;
    logic [8:0] vnext;

    always_comb begin
        line_end = hdump == HMAX;
        hnext    = line_end ? 9'd0 : hdump + 9'd1;
        vnext    = vrender;
        if (line_end) begin
            vnext = (vrender == VMAX) ? 9'd0 : vrender + 9'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdump   <= 9'd0;
            vrender <= 9'd0;
            LHBL    <= 1'b1;
            LVBL    <= 1'b1;
            HS      <= 1'b0;
            VS      <= 1'b0;
        end else if (pxl_cen) begin
            hdump   <= hnext;
            vrender <= vnext;
            LHBL    <= hnext < HVIS;
            LVBL    <= vnext < VVIS;
            HS      <= (hnext >= HS_START) && (hnext <= HS_END);
            // VS spans whole lines
            VS      <= (vnext >= VS_START) && (vnext <= VS_END);
        end
    end

endmodule

// ==== project.f ====
+incdir+.
jts16_pkg.sv
jts16_cen.sv
jts16_vtimer.sv
jts16_scroll.sv
jts16_rom_arb.sv
jts16_mix.sv
jts16_game.sv
jts16_game_assert.sv
jts16_game_tb.sv
